//--- counting_filter.f
filter_pkg.sv
remove_router.sv
bank_lookup.sv
counting_bank.sv
result_merge.sv
counting_filter.sv
counting_filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the counting filter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module counting_filter_tb -f counting_filter.f

output="$(./obj_dir/Vcounting_filter_tb)"
echo "$output"

if grep -qx "Result: PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- counting_filter_tb.sv
// Testbench for the two-bank counting filter
// Drives inserts, removes and lookups and checks the results against a count model

`timescale 1ns/1ps
`default_nettype none

module counting_filter_tb;
    import filter_pkg::*;

    // Expected lookup results of one request cycle
    typedef struct packed
    {
        logic          val_chk;
        bucket_value_t val_exp;
        logic          zero_chk;
        logic          zero_exp;
    } lookup_exp_t;

    localparam int max_count   = (1 << bucket_bits) - 1;
    localparam int burst_count = 8;
    localparam int burst_len   = 24;
    localparam int drain_len   = 12;
    // Directed tests need about 200 cycles and each burst adds a drain and a full scan
    localparam int test_cycles = 200 + burst_count * (burst_len + drain_len + num_buckets);
    // Three times the test length, rounded up to the next thousand
    localparam int max_cycles  = ((3 * test_cycles) / 1000 + 1) * 1000;

    logic          clk;
    logic          reset;
    bucket_idx_t   value_req;
    logic          value_en;
    bucket_idx_t   zero_req;
    logic          zero_en;
    bucket_idx_t   insert;
    logic          insert_en;
    bucket_idx_t   remove;
    logic          remove_en;
    logic          remove_not_full;
    bucket_value_t t3_value;
    logic          t3_is_zero;

    // Reference model, with removes held as pending until a drain
    int            model_count [num_buckets];
    int            pend [num_buckets];
    int            pend_total;
    logic          q_known;

    // Lookup expectations travel three cycles to meet the DUT results
    lookup_exp_t   exp_now;
    lookup_exp_t   exp_d1;
    lookup_exp_t   exp_d2;
    lookup_exp_t   exp_d3;
    logic          known_q;
    logic          flag_exp_q;

    int            val_checks = 0;
    int            zero_checks = 0;
    int            val_errors = 0;
    int            zero_errors = 0;
    int            flag_errors = 0;
    int            cycles = 0;

    counting_filter UUT
    (
        .clk             (clk),
        .reset           (reset),
        .value_req       (value_req),
        .value_en        (value_en),
        .zero_req        (zero_req),
        .zero_en         (zero_en),
        .insert          (insert),
        .insert_en       (insert_en),
        .remove          (remove),
        .remove_en       (remove_en),
        .remove_not_full (remove_not_full),
        .t3_value        (t3_value),
        .t3_is_zero      (t3_is_zero)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // ========================================
    // Delay line and checks
    // ========================================

    always @(posedge clk)
    begin
        // Queue flag as the model saw it one cycle before the DUT shows it
        known_q    <= q_known;
        flag_exp_q <= (pend_total < remove_depth);
        if (reset)
        begin
            exp_d1 <= '0;
            exp_d2 <= '0;
            exp_d3 <= '0;
        end
        else
        begin
            exp_d1 <= exp_now;
            exp_d2 <= exp_d1;
            exp_d3 <= exp_d2;
            if (exp_d3.val_chk)
            begin
                val_checks <= val_checks + 1;
            end
            if (exp_d3.zero_chk)
            begin
                zero_checks <= zero_checks + 1;
            end
        end
    end

    value_result: assert property (@(posedge clk) disable iff (reset)
        exp_d3.val_chk |-> (t3_value == exp_d3.val_exp))
        else
        begin
            val_errors++;
            $display("FAILED t3_value expected 0x%0h actual 0x%0h",
                     $sampled(exp_d3.val_exp), $sampled(t3_value));
        end

    zero_result: assert property (@(posedge clk) disable iff (reset)
        exp_d3.zero_chk |-> (t3_is_zero == exp_d3.zero_exp))
        else
        begin
            zero_errors++;
            $display("FAILED t3_is_zero expected 0x%0h actual 0x%0h",
                     $sampled(exp_d3.zero_exp), $sampled(t3_is_zero));
        end

    queue_flag: assert property (@(posedge clk) disable iff (reset)
        known_q |-> (remove_not_full == flag_exp_q))
        else
        begin
            flag_errors++;
            $display("FAILED remove_not_full expected 0x%0h actual 0x%0h",
                     $sampled(flag_exp_q), $sampled(remove_not_full));
        end

    task automatic report_counts();
        $display("Checks: %0d value, %0d zero; errors: %0d value, %0d zero, %0d queue flag",
                 val_checks, zero_checks, val_errors, zero_errors, flag_errors);
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout: the run went past %0d cycles", max_cycles);
            report_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    // ========================================
    // Stimulus tasks
    // ========================================

    // One clock cycle of stimulus, driven shortly after the rising edge
    task automatic do_cycle(input logic ins_en, input bucket_idx_t ins,
                            input logic rem_en, input bucket_idx_t rem,
                            input logic val_en, input bucket_idx_t val,
                            input logic zr_en, input bucket_idx_t zr);
        int in_bank [num_banks];

        @(posedge clk);
        #10;
        // A lookup counts updates of earlier cycles only, so judge it first
        // Pending removes leave the counts open until the next drain
        exp_now = '0;
        if (val_en && (pend_total == 0))
        begin
            exp_now.val_chk = 1'b1;
            exp_now.val_exp = bucket_value_t'(model_count[val]);
        end
        if (zr_en && (pend_total == 0))
        begin
            exp_now.zero_chk = 1'b1;
            exp_now.zero_exp = (model_count[zr] == 0);
        end

        // The queue count stays known while the insert claims the bank of every queued remove
        in_bank[0] = 0;
        in_bank[1] = 0;
        for (int b = 0; b < num_buckets; b++)
        begin
            in_bank[b % num_banks] += pend[b];
        end
        if ((pend_total > 0) && !(ins_en && (in_bank[ins[0]] == pend_total)))
        begin
            q_known = 1'b0;
        end

        if (ins_en)
        begin
            model_count[ins]++;
        end
        if (rem_en)
        begin
            pend[rem]++;
            pend_total++;
        end

        insert_en = ins_en;
        insert    = ins;
        remove_en = rem_en;
        remove    = rem;
        value_en  = val_en;
        value_req = val;
        zero_en   = zr_en;
        zero_req  = zr;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            do_cycle(1'b0, 4'h0, 1'b0, 4'h0, 1'b0, 4'h0, 1'b0, 4'h0);
        end
    endtask

    // Enough idle cycles for a full queue to issue and write back
    task automatic drain();
        idle(drain_len);
        for (int b = 0; b < num_buckets; b++)
        begin
            model_count[b] -= pend[b];
            pend[b] = 0;
        end
        pend_total = 0;
        q_known    = 1'b1;
    endtask

    // Value lookup of every bucket, zero lookup walking the other way
    task automatic scan_all();
        for (int b = 0; b < num_buckets; b++)
        begin
            do_cycle(1'b0, 4'h0, 1'b0, 4'h0, 1'b1, bucket_idx_t'(b),
                     1'b1, bucket_idx_t'(num_buckets - 1 - b));
        end
    endtask

    task automatic random_bursts();
        bucket_idx_t ins;
        bucket_idx_t rem;
        bucket_idx_t val;
        bucket_idx_t zr;
        logic        ins_en;
        logic        rem_en;

        for (int k = 0; k < burst_count; k++)
        begin
            for (int i = 0; i < burst_len; i++)
            begin
                ins    = bucket_idx_t'($urandom_range(num_buckets - 1));
                rem    = bucket_idx_t'($urandom_range(num_buckets - 1));
                val    = bucket_idx_t'($urandom_range(num_buckets - 1));
                zr     = bucket_idx_t'($urandom_range(num_buckets - 1));
                // Saturated buckets and removes that could underflow are skipped
                ins_en = ($urandom_range(1) == 1) && (model_count[ins] < max_count);
                rem_en = ($urandom_range(2) == 0) && (pend_total < remove_depth)
                         && ((model_count[rem] - pend[rem]) > 0);
                do_cycle(ins_en, ins, rem_en, rem, 1'b1, val, 1'b1, zr);
            end
            drain();
            scan_all();
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        bucket_idx_t spread [13];
        bucket_idx_t rem_list [8];

        void'($urandom(32'h69287f99));
        reset     = 1'b1;
        insert_en = 1'b0;
        insert    = '0;
        remove_en = 1'b0;
        remove    = '0;
        value_en  = 1'b0;
        value_req = '0;
        zero_en   = 1'b0;
        zero_req  = '0;
        exp_now   = '0;
        for (int b = 0; b < num_buckets; b++)
        begin
            model_count[b] = 0;
            pend[b]        = 0;
        end
        pend_total = 0;
        q_known    = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        // Cleared counters after reset
        scan_all();

        // Inserts spread over both banks, read back once settled
        spread = '{4'd0, 4'd0, 4'd0, 4'd1, 4'd1, 4'd6, 4'd9, 4'd9, 4'd9, 4'd9,
                   4'd14, 4'd14, 4'd15};
        for (int i = 0; i < 13; i++)
        begin
            do_cycle(1'b1, spread[i], 1'b0, 4'h0, 1'b0, 4'h0, 1'b0, 4'h0);
        end
        idle(3);
        scan_all();

        // Back to back inserts with lookups chasing them through the pipeline
        for (int i = 0; i < 6; i++)
        begin
            do_cycle(1'b1, 4'd5, 1'b0, 4'h0, 1'b1, 4'd5, 1'b1, 4'd5);
        end
        for (int i = 0; i < 6; i++)
        begin
            do_cycle(1'b1, i[0] ? 4'd5 : 4'd3, 1'b0, 4'h0, 1'b1, 4'd5, 1'b1, 4'd3);
        end
        for (int i = 0; i < 4; i++)
        begin
            do_cycle(1'b0, 4'h0, 1'b0, 4'h0, 1'b1, 4'd5, 1'b1, 4'd3);
        end

        // Removes in bank 1 while inserts keep bank 0 busy
        rem_list = '{4'd1, 4'd1, 4'd9, 4'd9, 4'd15, 4'd5, 4'd5, 4'd5};
        for (int i = 0; i < 8; i++)
        begin
            do_cycle(1'b1, bucket_idx_t'((i % 4) * 4 + 2 * (i / 4)), 1'b1, rem_list[i],
                     1'b0, 4'h0, 1'b0, 4'h0);
        end
        drain();
        scan_all();

        // Inserts hold bank 0 every cycle so the queue fills and stalls
        for (int i = 0; i < 12; i++)
        begin
            do_cycle(1'b1, i[0] ? 4'd8 : 4'd4, (i < remove_depth), i[0] ? 4'd8 : 4'd4,
                     1'b0, 4'h0, 1'b0, 4'h0);
        end
        drain();
        scan_all();

        random_bursts();
        idle(5);

        report_counts();
        if ((val_errors + zero_errors + flag_errors) == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- counting_filter.sv
// Two-bank counting filter top level
// Connects the remove router, both banks and the lookup result merge

`timescale 1ns/1ps
`default_nettype none

module counting_filter
(
    input  logic                       clk,
    input  logic                       reset,
    input  filter_pkg::bucket_idx_t    value_req,
    input  logic                       value_en,
    input  filter_pkg::bucket_idx_t    zero_req,
    input  logic                       zero_en,
    input  filter_pkg::bucket_idx_t    insert,
    input  logic                       insert_en,
    input  filter_pkg::bucket_idx_t    remove,
    input  logic                       remove_en,
    output logic                       remove_not_full,
    output filter_pkg::bucket_value_t  t3_value,
    output logic                       t3_is_zero
);
    import filter_pkg::*;

    bank_update_t  [num_banks-1:0] bank_update;
    bucket_value_t [num_banks-1:0] bank_value;
    bucket_value_t [num_banks-1:0] bank_zero_value;

    // Lookup requests split into bank and bucket within the bank
    bank_idx_t                     value_bank;
    bank_idx_t                     zero_bank;
    bank_bucket_idx_t              value_bucket;
    bank_bucket_idx_t              zero_bucket;

    assign value_bank   = bank_of(value_req);
    assign zero_bank    = bank_of(zero_req);
    assign value_bucket = bank_bucket_of(value_req);
    assign zero_bucket  = bank_bucket_of(zero_req);

    remove_router router
    (
        .clk             (clk),
        .reset           (reset),
        .insert          (insert),
        .insert_en       (insert_en),
        .remove          (remove),
        .remove_en       (remove_en),
        .remove_not_full (remove_not_full),
        .bank_update     (bank_update)
    );

    // Every bank sees every lookup and the merge keeps the addressed one
    for (genvar b = 0; b < num_banks; b++)
    begin : g_bank
        counting_bank bank
        (
            .clk           (clk),
            .reset         (reset),
            .update        (bank_update[b]),
            .value_bucket  (value_bucket),
            .zero_bucket   (zero_bucket),
            .t2_value      (bank_value[b]),
            .t2_zero_value (bank_zero_value[b])
        );
    end

    result_merge merge
    (
        .clk             (clk),
        .value_bank      (value_bank),
        .zero_bank       (zero_bank),
        .bank_value      (bank_value),
        .bank_zero_value (bank_zero_value),
        .t3_value        (t3_value),
        .t3_is_zero      (t3_is_zero)
    );

    // A requested lookup yields a defined result three cycles later
    value_result_known: assert property (@(posedge clk) disable iff (reset)
        $past(value_en, 3) |-> !$isunknown(t3_value))
        else $error("counting_filter: t3_value unknown after lookup");

    zero_result_known: assert property (@(posedge clk) disable iff (reset)
        $past(zero_en, 3) |-> !$isunknown(t3_is_zero))
        else $error("counting_filter: t3_is_zero unknown after lookup");

endmodule

`default_nettype wire

//--- result_merge.sv
// Lookup result merge across banks
// Selects the addressed bank and registers value and emptiness outputs

`timescale 1ns/1ps
`default_nettype none

module result_merge
(
    input  logic                                                  clk,
    input  filter_pkg::bank_idx_t                                 value_bank,
    input  filter_pkg::bank_idx_t                                 zero_bank,
    input  filter_pkg::bucket_value_t [filter_pkg::num_banks-1:0] bank_value,
    input  filter_pkg::bucket_value_t [filter_pkg::num_banks-1:0] bank_zero_value,
    output filter_pkg::bucket_value_t                             t3_value,
    output logic                                                  t3_is_zero
);
    import filter_pkg::*;

    // Bank numbers follow their lookups down the bank pipeline
    bank_idx_t     value_bank_q [1:lookup_stages-1];
    bank_idx_t     zero_bank_q [1:lookup_stages-1];

    // Count from the bank that served the zero lookup
    bucket_value_t zero_sel;

    always_ff @(posedge clk)
    begin
        value_bank_q[1] <= value_bank;
        zero_bank_q[1]  <= zero_bank;
        for (int p = 2; p < lookup_stages; p++)
        begin
            value_bank_q[p] <= value_bank_q[p-1];
            zero_bank_q[p]  <= zero_bank_q[p-1];
        end
    end

    assign zero_sel = bank_zero_value[zero_bank_q[lookup_stages-1]];

    // ========================================
    // Output registers
    // ========================================

    // Emptiness is derived here from the full count copy
    always_ff @(posedge clk)
    begin
        t3_value   <= bank_value[value_bank_q[lookup_stages-1]];
        t3_is_zero <= (zero_sel == '0);
    end

endmodule

`default_nettype wire

//--- counting_bank.sv
// One bank of the counting filter with a read-modify-write update pipeline
// Delta correction allows several updates to one bucket in flight at once

`timescale 1ns/1ps
`default_nettype none

module counting_bank
(
    input  logic                          clk,
    input  logic                          reset,
    input  filter_pkg::bank_update_t      update,
    input  filter_pkg::bank_bucket_idx_t  value_bucket,
    input  filter_pkg::bank_bucket_idx_t  zero_bucket,
    output filter_pkg::bucket_value_t     t2_value,
    output filter_pkg::bucket_value_t     t2_zero_value
);
    import filter_pkg::*;

    // Update side counters
    bucket_value_t counters [bank_buckets];

    // Stage 0 is the incoming update, stages 1 and 2 are registered copies
    bank_update_t  upd_q [1:lookup_stages-1];
    bucket_value_t delta_q [1:lookup_stages-1];
    bucket_value_t rd_q [1:lookup_stages-1];
    bucket_value_t delta0;

    bank_write_t   write;

    // Sequential reference counts used only by the checks below
    bucket_value_t shadow [bank_buckets];
    bucket_value_t shadow_next;

    // ========================================
    // Update pipeline
    // ========================================

    // The read taken at the end of stage 0 misses both older updates still
    // in flight, so their steps are folded into the delta here
    always_comb
    begin
        delta0 = kind_step(update.kind);
        for (int p = 1; p < lookup_stages; p++)
        begin
            if (upd_q[p].valid && (upd_q[p].bucket == update.bucket))
            begin
                delta0 = delta0 + kind_step(upd_q[p].kind);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        upd_q[1]   <= update;
        upd_q[2]   <= upd_q[1];
        delta_q[1] <= delta0;
        delta_q[2] <= delta_q[1];
        // Counter read plus one output register, like a block RAM read
        rd_q[1]    <= counters[update.bucket];
        rd_q[2]    <= rd_q[1];

        if (reset)
        begin
            upd_q[1].valid <= 1'b0;
            upd_q[2].valid <= 1'b0;
        end
    end

    // Stage 2 writes the corrected count back
    assign write.en     = upd_q[2].valid;
    assign write.bucket = upd_q[2].bucket;
    assign write.value  = rd_q[2] + delta_q[2];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < bank_buckets; b++)
            begin
                counters[b] <= '0;
            end
        end
        else if (write.en)
        begin
            counters[write.bucket] <= write.value;
        end
    end

    // ========================================
    // Lookup ports
    // ========================================

    // Each lookup class keeps its own counter copy fed by the bank writes
    bank_lookup value_lookup
    (
        .clk      (clk),
        .reset    (reset),
        .bucket   (value_bucket),
        .write    (write),
        .t2_value (t2_value)
    );

    bank_lookup zero_lookup
    (
        .clk      (clk),
        .reset    (reset),
        .bucket   (zero_bucket),
        .write    (write),
        .t2_value (t2_zero_value)
    );

    // ========================================
    // Counter checks
    // ========================================

    // Shadow counts apply each update in order with no bypass at all
    assign shadow_next = shadow[upd_q[2].bucket] + kind_step(upd_q[2].kind);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < bank_buckets; b++)
            begin
                shadow[b] <= '0;
            end
        end
        else if (upd_q[2].valid)
        begin
            shadow[upd_q[2].bucket] <= shadow_next;
        end
    end

    bucket_overflow: assert property (@(posedge clk) disable iff (reset)
        (upd_q[2].valid && (upd_q[2].kind == upd_insert)) |-> (shadow[upd_q[2].bucket] != '1))
        else $error("counting_bank: bucket 0x%0h overflow", upd_q[2].bucket);

    bucket_underflow: assert property (@(posedge clk) disable iff (reset)
        (upd_q[2].valid && (upd_q[2].kind == upd_remove)) |-> (shadow[upd_q[2].bucket] != '0))
        else $error("counting_bank: bucket 0x%0h underflow", upd_q[2].bucket);

    // The delta-corrected write must agree with plain sequential counting
    bucket_write_value: assert property (@(posedge clk) disable iff (reset)
        write.en |-> (write.value == shadow_next))
        else $error("counting_bank: bucket 0x%0h wrote 0x%0h expected 0x%0h",
                    write.bucket, write.value, shadow_next);

endmodule

`default_nettype wire

//--- bank_lookup.sv
// Lookup port of one bank with a registered counter read
// Writes seen during the read are tracked so the result stays current

`timescale 1ns/1ps
`default_nettype none

module bank_lookup
(
    input  logic                          clk,
    input  logic                          reset,
    input  filter_pkg::bank_bucket_idx_t  bucket,
    input  filter_pkg::bank_write_t       write,
    output filter_pkg::bucket_value_t     t2_value
);
    import filter_pkg::*;

    // Private copy of the bank counters
    bucket_value_t    mem [bank_buckets];

    // Read data and bypass state for stages 1 and 2
    bank_bucket_idx_t bucket1_q;
    bucket_value_t    rd1_q;
    bucket_value_t    rd2_q;
    logic             hit1_q;
    logic             hit2_q;
    bucket_value_t    hit_val1_q;
    bucket_value_t    hit_val2_q;

    // Write in the request cycle to the requested bucket
    logic             hit0;
    // Write in stage 1 to the tracked bucket
    logic             hit1;

    assign hit0 = write.en && (write.bucket == bucket);
    assign hit1 = write.en && (write.bucket == bucket1_q);

    // Mirrors every counter write of the bank
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < bank_buckets; b++)
            begin
                mem[b] <= '0;
            end
        end
        else if (write.en)
        begin
            mem[write.bucket] <= write.value;
        end
    end

    // ========================================
    // Read and bypass pipeline
    // ========================================

    // The read misses the write that lands on the same edge, and later
    // writes in stage 1 are newer than the read, so both are captured here
    // Writes in stage 2 belong to updates issued with this lookup and are
    // left out
    always_ff @(posedge clk)
    begin
        bucket1_q  <= bucket;
        rd1_q      <= mem[bucket];
        rd2_q      <= rd1_q;
        hit_val1_q <= write.value;
        hit1_q     <= hit0;
        hit2_q     <= hit1_q || hit1;
        hit_val2_q <= hit1 ? write.value : hit_val1_q;

        if (reset)
        begin
            hit1_q <= 1'b0;
            hit2_q <= 1'b0;
        end
    end

    // Newest snooped write wins over the memory read
    assign t2_value = hit2_q ? hit_val2_q : rd2_q;

endmodule

`default_nettype wire

//--- remove_router.sv
// Remove request queue and per-bank update routing
// Inserts always take their bank and the queue head fills a bank left idle

`timescale 1ns/1ps
`default_nettype none

module remove_router
(
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  filter_pkg::bucket_idx_t                              insert,
    input  logic                                                 insert_en,
    input  filter_pkg::bucket_idx_t                              remove,
    input  logic                                                 remove_en,
    output logic                                                 remove_not_full,
    output filter_pkg::bank_update_t [filter_pkg::num_banks-1:0] bank_update
);
    import filter_pkg::*;

    // Circular queue of pending remove buckets
    bucket_idx_t   queue_mem [remove_depth];
    remove_ptr_t   wr_ptr;
    remove_ptr_t   rd_ptr;
    remove_count_t count;

    logic          push;
    logic          pop;
    logic          head_valid;
    bucket_idx_t   head;
    bank_idx_t     head_bank;
    bank_idx_t     insert_bank;

    // ========================================
    // Remove queue
    // ========================================

    assign remove_not_full = (count != remove_count_t'(remove_depth));
    assign push            = remove_en && remove_not_full;

    // The head always comes straight out of the queue registers
    assign head_valid  = (count != '0);
    assign head        = queue_mem[rd_ptr];
    assign head_bank   = bank_of(head);
    assign insert_bank = bank_of(insert);

    // The head leaves only when an insert is not claiming its bank
    assign pop = head_valid && !(insert_en && (insert_bank == head_bank));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + remove_count_t'(push) - remove_count_t'(pop);
        end
    end

    // A pushed entry becomes visible as head one cycle later at the earliest
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            queue_mem[wr_ptr] <= remove;
        end
    end

    // ========================================
    // Per-bank update select
    // ========================================

    always_comb
    begin
        for (int b = 0; b < num_banks; b++)
        begin
            bank_update[b].valid  = 1'b0;
            bank_update[b].kind   = upd_insert;
            bank_update[b].bucket = bank_bucket_of(insert);
            if (insert_en && (insert_bank == bank_idx_t'(b)))
            begin
                bank_update[b].valid = 1'b1;
            end
            else if (head_valid && (head_bank == bank_idx_t'(b)))
            begin
                bank_update[b].valid  = 1'b1;
                bank_update[b].kind   = upd_remove;
                bank_update[b].bucket = bank_bucket_of(head);
            end
        end
    end

    // Clients must hold off removes while the queue reports full
    remove_push_when_full: assert property (@(posedge clk) disable iff (reset)
        remove_en |-> remove_not_full)
        else $error("remove_router: remove_en while queue full");

    // A dequeued remove goes out as the only update of its bank
    remove_head_issued: assert property (@(posedge clk) disable iff (reset)
        pop |-> (bank_update[head_bank].valid
                 && (bank_update[head_bank].kind == upd_remove)
                 && (bank_update[head_bank].bucket == bank_bucket_of(head))))
        else $error("remove_router: dequeued remove not issued to bank %0d", head_bank);

endmodule

`default_nettype wire

//--- filter_pkg.sv
// Shared types and sizes for the two-bank counting filter
// Holds bucket widths, the update kind enum and the bank-side packed structs

`default_nettype none

package filter_pkg;

    // ========================================
    // Sizes
    // ========================================

    localparam int num_buckets   = 16;
    localparam int num_banks     = 2;
    localparam int bank_buckets  = num_buckets / num_banks;
    localparam int bucket_bits   = 4;
    localparam int remove_depth  = 8;
    // Lookups and updates share this pipeline length
    localparam int lookup_stages = 3;

    // ========================================
    // Types
    // ========================================

    typedef logic [$clog2(num_buckets)-1:0]    bucket_idx_t;
    // The low bit of a bucket number picks the bank
    typedef logic [$clog2(num_banks)-1:0]      bank_idx_t;
    // The remaining upper bits address a bucket inside its bank
    typedef logic [$clog2(bank_buckets)-1:0]   bank_bucket_idx_t;
    typedef logic [bucket_bits-1:0]            bucket_value_t;
    typedef logic [$clog2(remove_depth)-1:0]   remove_ptr_t;
    typedef logic [$clog2(remove_depth+1)-1:0] remove_count_t;

    typedef enum logic
    {
        upd_insert = 1'b0,
        upd_remove = 1'b1
    } update_kind_e;

    // One update issued to a bank in a cycle
    typedef struct packed
    {
        logic             valid;
        update_kind_e     kind;
        bank_bucket_idx_t bucket;
    } bank_update_t;

    // Counter write of a bank, also snooped by its lookup ports
    typedef struct packed
    {
        logic             en;
        bank_bucket_idx_t bucket;
        bucket_value_t    value;
    } bank_write_t;

    function automatic bank_idx_t bank_of(bucket_idx_t idx);
        return idx[$bits(bank_idx_t)-1:0];
    endfunction

    function automatic bank_bucket_idx_t bank_bucket_of(bucket_idx_t idx);
        return idx[$bits(bucket_idx_t)-1:$bits(bank_idx_t)];
    endfunction

    // Signed step of one update, kept modulo the counter width
    function automatic bucket_value_t kind_step(update_kind_e kind);
        return (kind == upd_insert) ? bucket_value_t'(1) : bucket_value_t'(-1);
    endfunction

endpackage

`default_nettype wire
